// File: files.f
verilog/a2_pkg.sv
verilog/edge_sync.sv
verilog/card_response_arbiter.sv
verilog/credit_fifo.sv
verilog/audio_mixer.sv
verilog/a2_card_frontend.sv
bench/a2_card_frontend_sva.sv
bench/tb_a2_card_frontend.sv

// File: bench/tb_a2_card_frontend.sv
// Testbench for the Apple II card bus front end.
// Runs clock recovery, arbiter table and the two audio credit scenarios,
// comparing against values worked out from the bus and mixing rules.

`timescale 1ns/1ns
`default_nettype none

module tb_a2_card_frontend;
    import a2_pkg::*;

    localparam int SINK_CREDITS = 2;
    localparam int SRC_DEPTH    = 4;
    localparam int NUM_ARB_ROWS = 8;
    localparam int NUM_AUD_ROWS = 16;
    localparam int CYCLE_LIMIT  = 40 * (NUM_ARB_ROWS + NUM_AUD_ROWS) + 200;

    typedef struct packed {
        logic [3:0]  rd_en;
        logic [31:0] data;
        logic [7:0]  bus;
        logic [2:0]  irq_n;
        logic [7:0]  exp_data;
        logic        exp_en;
        logic        exp_irq_n;
    } arb_row_t;

    logic clk_logic_w, rst_n_i, a2_phi1_i, a2_7m_i;
    logic [3:0] card_rd_en_i;
    logic [3:0][7:0] card_data_i;
    logic [7:0] bus_data_i, data_out_o;
    logic [2:0] irq_n_i;
    logic data_out_en_o, irq_n_o, phi0_o, phi1_posedge_o, phi1_negedge_o, clk_14m_posedge_o;
    logic audio_valid_i, speaker_i, audio_credit_o, sample_valid_o, sample_credit_i;
    logic [15:0] ssp_audio_i, sample_l_o, sample_r_o;
    logic [9:0] mb_audio_l_i, mb_audio_r_i;

    arb_row_t    arb_tab [NUM_ARB_ROWS];
    logic [15:0] aud_ssp [NUM_AUD_ROWS];
    logic [9:0]  aud_mbl [NUM_AUD_ROWS];
    logic [9:0]  aud_mbr [NUM_AUD_ROWS];
    logic        aud_spk [NUM_AUD_ROWS];
    logic [31:0] exp_q [$];

    int cycle_cnt = 0;
    int fail_cnt = 0;
    int src_credits, pend_credits, credits_seen, samples_seen, pushed, next_row;
    int first_push_cyc, first_sample_cyc;
    bit credits_open;

    a2_card_frontend i_dut (.*);

    bind audio_mixer a2_card_frontend_sva #(.SINK_CREDITS(SINK_CREDITS)) i_sva (
        .clk_logic_w     (clk_logic_w),
        .rst_n_i         (rst_n_i),
        .credit_cnt_i    (credit_cnt),
        .empty_i         (empty_i),
        .pop_i           (pop_o),
        .sample_valid_i  (sample_valid_o),
        .sample_credit_i (sample_credit_i)
    );

    initial begin
        clk_logic_w = 1'b0;
        forever #5 clk_logic_w = ~clk_logic_w;
    end

    always @(posedge clk_logic_w) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_run();
        fail_cnt++;
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, act, exp);
            stop_run();
        end
    endtask

    // Stereo rule: sprite + (MB << 5) + (speaker << 13), kept to 16 bits
    function automatic logic [15:0] mix_rule(logic [15:0] ssp, logic [9:0] mb, logic spk);
        logic [31:0] wide;
        wide = 32'(ssp) + (32'(mb) << MB_SHIFT) + (32'(spk) << SPEAKER_SHIFT);
        return wide[15:0];
    endfunction

    // One cycle of the audio links, called right after a falling edge
    task automatic audio_cycle(input int last_row);
        logic [31:0] pair;
        sample_credit_i = 1'b0;
        if (audio_credit_o) begin
            credits_seen++;
            src_credits++;
        end
        if (sample_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t ns: sample arrived with no input pending", $time);
                stop_run();
            end else begin
                pair = exp_q.pop_front();
                if (samples_seen == 0) first_sample_cyc = cycle_cnt;
                samples_seen++;
                pend_credits++;
                check_value("sample_l_o", sample_l_o, pair[31:16]);
                check_value("sample_r_o", sample_r_o, pair[15:0]);
            end
        end
        // Sink hands back one credit per cycle while open
        if (credits_open && pend_credits > 0) begin
            sample_credit_i = 1'b1;
            pend_credits--;
        end
        audio_valid_i = 1'b0;
        if (next_row < last_row && src_credits > 0) begin
            audio_valid_i = 1'b1;
            ssp_audio_i   = aud_ssp[next_row];
            mb_audio_l_i  = aud_mbl[next_row];
            mb_audio_r_i  = aud_mbr[next_row];
            speaker_i     = aud_spk[next_row];
            exp_q.push_back({mix_rule(aud_ssp[next_row], aud_mbl[next_row], aud_spk[next_row]),
                             mix_rule(aud_ssp[next_row], aud_mbr[next_row], aud_spk[next_row])});
            if (pushed == 0) first_push_cyc = cycle_cnt;
            pushed++;
            next_row++;
            src_credits--;
        end
    endtask

    initial begin
        int ticks;
        void'($urandom(32'hc9c9));
        {rst_n_i, a2_phi1_i, a2_7m_i, card_rd_en_i, card_data_i, bus_data_i} = '0;
        irq_n_i = 3'b111;
        {audio_valid_i, ssp_audio_i, mb_audio_l_i, mb_audio_r_i, speaker_i} = '0;
        sample_credit_i = 1'b0;
        {pend_credits, credits_seen, samples_seen, pushed, next_row} = '0;
        src_credits = SRC_DEPTH;
        arb_tab[0] = '{4'b0000, 32'h44332211, 8'ha5, 3'b111, 8'ha5, 1'b0, 1'b1};
        arb_tab[1] = '{4'b0001, 32'h44332211, 8'ha5, 3'b110, 8'h11, 1'b1, 1'b0};
        arb_tab[2] = '{4'b0010, 32'h44332211, 8'h5a, 3'b101, 8'h22, 1'b1, 1'b0};
        arb_tab[3] = '{4'b0100, 32'h44332211, 8'h5a, 3'b011, 8'h33, 1'b1, 1'b0};
        arb_tab[4] = '{4'b1000, 32'h44332211, 8'h00, 3'b111, 8'h44, 1'b1, 1'b1};
        arb_tab[5] = '{4'b1111, 32'h99887766, 8'hff, 3'b000, 8'h66, 1'b1, 1'b0};
        arb_tab[6] = '{4'b1110, 32'hcafef00d, 8'h3c, 3'b111, 8'hf0, 1'b1, 1'b1};
        arb_tab[7] = '{4'b1100, 32'h01020304, 8'hc3, 3'b111, 8'h02, 1'b1, 1'b1};
        for (int i = 0; i < NUM_AUD_ROWS; i++) begin
            aud_ssp[i] = 16'($urandom);
            aud_mbl[i] = 10'($urandom);
            aud_mbr[i] = 10'($urandom);
            aud_spk[i] = 1'($urandom);
        end
        // Full-scale row to exercise the 16-bit wrap
        {aud_ssp[0], aud_mbl[0], aud_mbr[0], aud_spk[0]} = {16'hfff0, 10'h3ff, 10'h200, 1'b1};

        repeat (3) @(negedge clk_logic_w);
        rst_n_i = 1'b1;
        check_value("data_out_en_o", data_out_en_o, 0);
        check_value("sample_valid_o", sample_valid_o, 0);
        check_value("audio_credit_o", audio_credit_o, 0);
        check_value("irq_n_o", irq_n_o, 1);
        check_value("phi1_posedge_o", phi1_posedge_o, 0);
        check_value("phi1_negedge_o", phi1_negedge_o, 0);
        check_value("clk_14m_posedge_o", clk_14m_posedge_o, 0);

        // phi1 rise shows as a pulse on the third edge after the change
        repeat (2) begin
            a2_phi1_i = 1'b1;
            for (int c = 1; c <= 5; c++) begin
                @(negedge clk_logic_w);
                check_value("phi1_posedge_o", phi1_posedge_o, (c == 3));
                check_value("phi0_o", phi0_o, (c < 3));
            end
            a2_phi1_i = 1'b0;
            for (int c = 1; c <= 5; c++) begin
                @(negedge clk_logic_w);
                check_value("phi1_negedge_o", phi1_negedge_o, (c == 3));
                check_value("phi0_o", phi0_o, (c >= 3));
            end
        end

        ticks = 0;
        for (int t = 0; t < 28; t++) begin
            if (t < 24 && t % 3 == 0) a2_7m_i = ~a2_7m_i;
            @(negedge clk_logic_w);
            if (clk_14m_posedge_o) ticks++;
        end
        check_value("clk_14m_posedge_o count", ticks, 8);

        for (int r = 0; r < NUM_ARB_ROWS; r++) begin
            card_rd_en_i = arb_tab[r].rd_en;
            card_data_i  = arb_tab[r].data;
            bus_data_i   = arb_tab[r].bus;
            irq_n_i      = arb_tab[r].irq_n;
            @(negedge clk_logic_w);
            check_value("data_out_o", data_out_o, arb_tab[r].exp_data);
            check_value("data_out_en_o", data_out_en_o, arb_tab[r].exp_en);
            check_value("irq_n_o", irq_n_o, arb_tab[r].exp_irq_n);
        end

        // Prompt sink credits, first half of the audio table
        credits_open = 1'b1;
        while (samples_seen < NUM_AUD_ROWS / 2) begin
            @(negedge clk_logic_w);
            audio_cycle(NUM_AUD_ROWS / 2);
        end
        check_value("first sample latency", first_sample_cyc - first_push_cyc, 2);

        // Credits withheld, then released
        credits_open = 1'b0;
        repeat (30) begin
            @(negedge clk_logic_w);
            audio_cycle(NUM_AUD_ROWS);
        end
        check_value("samples while withheld", samples_seen - NUM_AUD_ROWS / 2, SINK_CREDITS);
        credits_open = 1'b1;
        while (samples_seen < NUM_AUD_ROWS) begin
            @(negedge clk_logic_w);
            audio_cycle(NUM_AUD_ROWS);
        end
        repeat (4) begin
            @(negedge clk_logic_w);
            audio_cycle(NUM_AUD_ROWS);
        end
        check_value("samples sent", samples_seen, pushed);
        check_value("audio_credit_o pulses", credits_seen, samples_seen);

        if (fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/a2_card_frontend_sva.sv
// Credit accounting checks for the audio mixer.
// Bound into audio_mixer from the testbench top module.

`timescale 1ns/1ns
`default_nettype none

module a2_card_frontend_sva
    import a2_pkg::*;
#(
    parameter int SINK_CREDITS = 2
) (
    input  wire                 clk_logic_w,
    input  wire                 rst_n_i,
    input  logic [CREDIT_W-1:0] credit_cnt_i,
    input  logic                empty_i,
    input  logic                pop_i,
    input  logic                sample_valid_i,
    input  logic                sample_credit_i
);

    // Credits the sink has granted, counted from the link alone
    logic [CREDIT_W-1:0] held_r;

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            held_r <= CREDIT_W'(SINK_CREDITS);
        end else begin
            case ({sample_valid_i, sample_credit_i})
                2'b10:   held_r <= held_r - 1'b1;
                2'b01:   held_r <= held_r + 1'b1;
                default: held_r <= held_r;
            endcase
        end
    end

    // Returned credits never pile up beyond the sink's slots
    credit_bound_a : assert property (
        @(posedge clk_logic_w) disable iff (!rst_n_i)
        credit_cnt_i <= CREDIT_W'(SINK_CREDITS)
    ) else $error("mixer credit count above SINK_CREDITS");

    // Every sample on the link needs a credit the sink has granted
    valid_needs_credit_a : assert property (
        @(posedge clk_logic_w) disable iff (!rst_n_i)
        sample_valid_i |-> (held_r != '0)
    ) else $error("sample sent without a sink credit");

    no_pop_when_empty_a : assert property (
        @(posedge clk_logic_w) disable iff (!rst_n_i)
        pop_i |-> !empty_i
    ) else $error("pop while source FIFO empty");

endmodule

`default_nettype wire

// File: verilog/a2_card_frontend.sv
// Apple II card bus front end, top level.
// Recovers phi0/phi1 and 14M timing from the Apple clock pins,
// arbitrates the card's data byte and IRQ onto the bus, and runs
// the audio sources through a credit FIFO into the stereo mixer.

`timescale 1ns/1ns
`default_nettype none

module a2_card_frontend
    import a2_pkg::*;
#(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1,
    parameter int SRC_DEPTH           = 4,
    parameter int SINK_CREDITS        = 2
) (
    input  wire                                    clk_logic_w,
    input  wire                                    rst_n_i,

    // Apple clock pins
    input  wire                                    a2_phi1_i,
    input  wire                                    a2_7m_i,

    // Card responses and bus inputs
    input  wire  [NUM_CARDS-1:0]                   card_rd_en_i,
    input  wire  [NUM_CARDS-1:0][BUS_DATA_W-1:0]   card_data_i,
    input  wire  [BUS_DATA_W-1:0]                  bus_data_i,
    input  wire  [NUM_IRQ_SRC-1:0]                 irq_n_i,

    // Bus outputs
    output logic                                   data_out_en_o,
    output logic [BUS_DATA_W-1:0]                  data_out_o,
    output logic                                   irq_n_o,

    // Recovered timing
    output logic                                   phi0_o,
    output logic                                   phi1_posedge_o,
    output logic                                   phi1_negedge_o,
    output logic                                   clk_14m_posedge_o,

    // Audio sources, credited upstream
    input  wire                                    audio_valid_i,
    input  wire  [SSP_AUDIO_W-1:0]                 ssp_audio_i,
    input  wire  [MB_AUDIO_W-1:0]                  mb_audio_l_i,
    input  wire  [MB_AUDIO_W-1:0]                  mb_audio_r_i,
    input  wire                                    speaker_i,
    output logic                                   audio_credit_o,

    // Mixed samples, credited downstream
    output logic                                   sample_valid_o,
    output logic [MIX_W-1:0]                       sample_l_o,
    output logic [MIX_W-1:0]                       sample_r_o,
    input  wire                                    sample_credit_i
);

    logic clk_7m_posedge_w;
    logic clk_7m_negedge_w;

    card_rsp_t [NUM_CARDS-1:0] card_rsp_w;
    audio_src_t                src_in_w;
    audio_src_t                src_head_w;
    logic                      src_empty_w;
    logic                      src_pop_w;
    stereo_sample_t            sample_w;

    // phi0 is the inverse of phi1
    edge_sync u_phi1_sync (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .pin_i       (a2_phi1_i),
        .level_o     (),
        .level_n_o   (phi0_o),
        .posedge_o   (phi1_posedge_o),
        .negedge_o   (phi1_negedge_o)
    );

    edge_sync u_7m_sync (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .pin_i       (a2_7m_i),
        .level_o     (),
        .level_n_o   (),
        .posedge_o   (clk_7m_posedge_w),
        .negedge_o   (clk_7m_negedge_w)
    );

    // Both 7M edges make the 14M tick
    assign clk_14m_posedge_o = clk_7m_posedge_w | clk_7m_negedge_w;

    for (genvar i = 0; i < NUM_CARDS; i++) begin : g_card_rsp
        assign card_rsp_w[i].rd_en = card_rd_en_i[i];
        assign card_rsp_w[i].data  = card_data_i[i];
    end

    card_response_arbiter #(
        .BUS_DATA_OUT_ENABLE (BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE      (IRQ_OUT_ENABLE)
    ) u_arbiter (
        .clk_logic_w   (clk_logic_w),
        .rst_n_i       (rst_n_i),
        .card_rsp_i    (card_rsp_w),
        .bus_data_i    (bus_data_i),
        .irq_n_i       (irq_n_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    assign src_in_w.ssp     = ssp_audio_i;
    assign src_in_w.mb_l    = mb_audio_l_i;
    assign src_in_w.mb_r    = mb_audio_r_i;
    assign src_in_w.speaker = speaker_i;

    credit_fifo #(
        .item_t (audio_src_t),
        .DEPTH  (SRC_DEPTH)
    ) u_src_fifo (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .push_i      (audio_valid_i),
        .item_i      (src_in_w),
        .pop_i       (src_pop_w),
        .head_o      (src_head_w),
        .empty_o     (src_empty_w),
        .credit_o    (audio_credit_o)
    );

    audio_mixer #(
        .SINK_CREDITS (SINK_CREDITS)
    ) u_mixer (
        .clk_logic_w     (clk_logic_w),
        .rst_n_i         (rst_n_i),
        .head_i          (src_head_w),
        .empty_i         (src_empty_w),
        .pop_o           (src_pop_w),
        .sample_o        (sample_w),
        .sample_valid_o  (sample_valid_o),
        .sample_credit_i (sample_credit_i)
    );

    assign sample_l_o = sample_w.left;
    assign sample_r_o = sample_w.right;

endmodule

`default_nettype wire

// File: verilog/audio_mixer.sv
// Stereo mixer between the source FIFO and the downstream sink.
// Pops a source tuple when one is waiting and a sink credit is held,
// sums sprite, Mockingboard and speaker with their shifts, and sends
// the registered sample. Credits come back as one-cycle pulses.

`timescale 1ns/1ns
`default_nettype none

module audio_mixer
    import a2_pkg::*;
#(
    parameter int SINK_CREDITS = 2
) (
    input  wire            clk_logic_w,
    input  wire            rst_n_i,
    input  audio_src_t     head_i,
    input  logic           empty_i,
    output logic           pop_o,
    output stereo_sample_t sample_o,
    output logic           sample_valid_o,
    input  logic           sample_credit_i
);

    logic [CREDIT_W-1:0] credit_cnt;
    logic [MIX_W-1:0]    common_sum;
    logic [MIX_W-1:0]    mb_l_term;
    logic [MIX_W-1:0]    mb_r_term;
    stereo_sample_t      mix;

    // Send only while the sink has room
    assign pop_o = !empty_i && (credit_cnt != '0);

    // Scale the narrow sources up, wrapping to the mix width
    assign mb_l_term  = MIX_W'(head_i.mb_l) << MB_SHIFT;
    assign mb_r_term  = MIX_W'(head_i.mb_r) << MB_SHIFT;
    assign common_sum = MIX_W'(head_i.ssp) + (MIX_W'(head_i.speaker) << SPEAKER_SHIFT);

    assign mix.left  = common_sum + mb_l_term;
    assign mix.right = common_sum + mb_r_term;

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_cnt     <= CREDIT_W'(SINK_CREDITS);
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= pop_o;
            // Spend and return can land in the same cycle
            case ({pop_o, sample_credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (pop_o) begin
            sample_o <= mix;
        end
    end

endmodule

`default_nettype wire

// File: verilog/credit_fifo.sv
// Small circular FIFO for any item type, with credit return.
// The sender starts with DEPTH credits and spends one per push.
// Each pop frees a slot and pulses credit_o in the following cycle.
// The head item is visible without a pop, so the reader looks first.

`timescale 1ns/1ns
`default_nettype none

module credit_fifo
    import a2_pkg::*;
#(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  wire   clk_logic_w,
    input  wire   rst_n_i,
    input  logic  push_i,
    input  item_t item_i,
    input  logic  pop_i,
    output item_t head_o,
    output logic  empty_o,
    output logic  credit_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    item_t               mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] count_r;
    logic                pop_ok;

    assign empty_o = (count_r == '0);
    assign head_o  = mem[rd_ptr];
    assign pop_ok  = pop_i && !empty_o;

    // Storage, written on every push
    always_ff @(posedge clk_logic_w) begin
        if (push_i) begin
            mem[wr_ptr] <= item_i;
        end
    end

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count_r  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Fill count tracks push and pop in the same cycle
            case ({push_i, pop_ok})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
            // One slot freed, one credit back to the sender
            credit_o <= pop_ok;
        end
    end

endmodule

`default_nettype wire

// File: verilog/card_response_arbiter.sv
// Chooses the byte the card drives onto the Apple data bus.
// Fixed priority: serial, sprite, Mockingboard, then Disk II.
// Also merges the active-low card interrupts into one bus IRQ.
// Outputs are registered, one cycle after the inputs.

`timescale 1ns/1ns
`default_nettype none

module card_response_arbiter
    import a2_pkg::*;
#(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1
) (
    input  wire                              clk_logic_w,
    input  wire                              rst_n_i,
    input  card_rsp_t [NUM_CARDS-1:0]        card_rsp_i,
    input  logic      [BUS_DATA_W-1:0]       bus_data_i,
    input  logic      [NUM_IRQ_SRC-1:0]      irq_n_i,
    output logic                             data_out_en_o,
    output logic      [BUS_DATA_W-1:0]       data_out_o,
    output logic                             irq_n_o
);

    card_idx_e             sel_idx;
    logic                  any_rd;
    logic [BUS_DATA_W-1:0] next_data;

    // Walk from lowest to highest priority so the highest one wins
    always_comb begin
        any_rd  = 1'b0;
        sel_idx = CARD_DISKII;
        for (int i = NUM_CARDS - 1; i >= 0; i--) begin
            if (card_rsp_i[i].rd_en) begin
                any_rd  = 1'b1;
                sel_idx = card_idx_e'(i);
            end
        end
    end

    // No reader means the bus byte passes through undriven
    assign next_data = any_rd ? card_rsp_i[sel_idx].data : bus_data_i;

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_out_en_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            data_out_en_o <= BUS_DATA_OUT_ENABLE ? any_rd : 1'b0;
            // Any card pulling low asserts the bus IRQ
            irq_n_o       <= IRQ_OUT_ENABLE ? &irq_n_i : 1'b1;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        data_out_o <= next_data;
    end

endmodule

`default_nettype wire

// File: verilog/edge_sync.sv
// Brings one asynchronous Apple clock pin into the logic clock domain.
// Gives the synchronized level, its inverse, and one-cycle pulses
// on rising and falling edges, two cycles after the pin is sampled.

`timescale 1ns/1ns
`default_nettype none

module edge_sync (
    input  wire  clk_logic_w,
    input  wire  rst_n_i,
    input  logic pin_i,
    output logic level_o,
    output logic level_n_o,
    output logic posedge_o,
    output logic negedge_o
);

    logic meta_r;
    logic sync_r;
    logic hist_r;

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_r    <= 1'b0;
            sync_r    <= 1'b0;
            hist_r    <= 1'b0;
            posedge_o <= 1'b0;
            negedge_o <= 1'b0;
        end else begin
            meta_r    <= pin_i;
            sync_r    <= meta_r;
            hist_r    <= sync_r;
            // Edge seen when the synced value differs from history
            posedge_o <= sync_r & ~hist_r;
            negedge_o <= ~sync_r & hist_r;
        end
    end

    // History flop doubles as the level, aligned with the pulses
    assign level_o   = hist_r;
    assign level_n_o = ~hist_r;

endmodule

`default_nettype wire

// File: verilog/a2_pkg.sv
// Shared definitions for the Apple II card bus front end.
// Bus widths, card priority order, audio widths and mixing shifts,
// and the payload structs carried between pipeline stages.
// Modules pull these in with a wildcard import in their header.

`default_nettype none

package a2_pkg;

    // Apple bus
    localparam int BUS_DATA_W  = 8;
    localparam int NUM_CARDS   = 4;
    localparam int NUM_IRQ_SRC = 3;

    // Card positions, highest priority first
    typedef enum logic [1:0] {
        CARD_SSC    = 2'd0,
        CARD_SSP    = 2'd1,
        CARD_MB     = 2'd2,
        CARD_DISKII = 2'd3
    } card_idx_e;

    // One card's answer to a bus read
    typedef struct packed {
        logic                  rd_en;
        logic [BUS_DATA_W-1:0] data;
    } card_rsp_t;

    // Audio widths
    localparam int SSP_AUDIO_W = 16;
    localparam int MB_AUDIO_W  = 10;
    localparam int MIX_W       = 16;

    // Scaling of the smaller sources before summing
    localparam int MB_SHIFT      = 5;
    localparam int SPEAKER_SHIFT = 13;

    // Raw source tuple, 37 bits
    typedef struct packed {
        logic [SSP_AUDIO_W-1:0] ssp;
        logic [MB_AUDIO_W-1:0]  mb_l;
        logic [MB_AUDIO_W-1:0]  mb_r;
        logic                   speaker;
    } audio_src_t;

    // Mixed stereo output
    typedef struct packed {
        logic [MIX_W-1:0] left;
        logic [MIX_W-1:0] right;
    } stereo_sample_t;

    // Credit counters and FIFO fill counts, max 15
    localparam int CREDIT_W = 4;

endpackage

`default_nettype wire
